// ==== logic/mem_pkg.sv ====
package mem_pkg;

    ////////////////////////////////////////////////////////////
    // Data path geometry
    ////////////////////////////////////////////////////////////

    // Word width seen by the host and the memory
    localparam int DATA_W = 32;
    // Byte lanes per word
    localparam int LANES = 4;

    ////////////////////////////////////////////////////////////
    // Access width and signedness, carried on pauser
    ////////////////////////////////////////////////////////////

    // Signed variants sign-extend on loads
    // Signedness has no effect on stores
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'd0,
        MEM_BYTE_U = 3'd1,
        MEM_HALF   = 3'd2,
        MEM_HALF_U = 3'd3,
        MEM_WORD   = 3'd4
    } mem_op_e;

    ////////////////////////////////////////////////////////////
    // APB slave front-end phases
    ////////////////////////////////////////////////////////////

    // Idle or setup, first access cycle, response cycle
    typedef enum logic [1:0] {
        APB_IDLE   = 2'd0,
        APB_ACCESS = 2'd1,
        APB_RESP   = 2'd2
    } apb_state_e;

endpackage

// ==== logic/access_align.sv ====
module access_align (
    input  logic [1:0]                  align_offset,
    input  mem_pkg::mem_op_e            align_op,
    input  logic [mem_pkg::DATA_W-1:0]  align_wdata,
    output logic [mem_pkg::LANES-1:0]   lane_sel,
    output logic [mem_pkg::DATA_W-1:0]  lane_wdata,
    output logic                        load_signed,
    output logic                        misaligned
);

    // Lane geometry
    localparam int BYTE_W  = mem_pkg::DATA_W / mem_pkg::LANES;
    localparam int HALF_W  = 2 * BYTE_W;
    localparam int SHIFT_W = $clog2(mem_pkg::DATA_W);

    // Bit distance from lane 0 to the addressed lane
    logic [SHIFT_W-1:0] byte_shift;

    assign byte_shift = SHIFT_W'(align_offset) * SHIFT_W'(BYTE_W);

    // Signed loads for byte, half-word and word
    assign load_signed = (align_op == mem_pkg::MEM_BYTE) ||
                         (align_op == mem_pkg::MEM_HALF) ||
                         (align_op == mem_pkg::MEM_WORD);

    ////////////////////////////////////////////////////////////
    // Width and offset decode
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        lane_sel   = '0;
        lane_wdata = '0;
        misaligned = 1'b0;
        case (align_op)
            mem_pkg::MEM_BYTE, mem_pkg::MEM_BYTE_U:
            begin
                // Any offset is legal for a byte
                lane_sel   = mem_pkg::LANES'(1) << align_offset;
                lane_wdata = mem_pkg::DATA_W'(align_wdata[BYTE_W-1:0]) << byte_shift;
            end
            mem_pkg::MEM_HALF, mem_pkg::MEM_HALF_U:
            begin
                // Offset 0 or 2 only
                misaligned = align_offset[0];
                lane_sel   = mem_pkg::LANES'(3) << align_offset;
                lane_wdata = mem_pkg::DATA_W'(align_wdata[HALF_W-1:0]) << byte_shift;
            end
            mem_pkg::MEM_WORD:
            begin
                // Word must start on lane 0
                misaligned = (align_offset != 2'd0);
                lane_sel   = '1;
                lane_wdata = align_wdata;
            end
            default:
            begin
                // Unknown width code is refused like a bad offset
                misaligned = 1'b1;
            end
        endcase
        // No lanes on a refused access
        if (misaligned)
        begin
            lane_sel = '0;
        end
    end

endmodule

// ==== logic/data_ram.sv ====
module data_ram #(
    parameter int ADDR_BITS = 10
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        ram_en,
    input  logic                        ram_write,
    input  logic [ADDR_BITS-3:0]        ram_addr,
    input  logic [mem_pkg::LANES-1:0]   ram_sel,
    input  logic [mem_pkg::DATA_W-1:0]  ram_wdata,
    input  logic                        ram_signed,
    input  logic [ADDR_BITS-3:0]        display_addr,
    output logic [mem_pkg::DATA_W-1:0]  ram_rdata,
    output logic [mem_pkg::DATA_W-1:0]  display_data
);

    localparam int DEPTH  = 1 << (ADDR_BITS - 2);
    localparam int BYTE_W = mem_pkg::DATA_W / mem_pkg::LANES;
    localparam int HALF_W = 2 * BYTE_W;

    // Word storage
    logic [mem_pkg::DATA_W-1:0] mem [DEPTH];

    logic [mem_pkg::DATA_W-1:0] cur_word;
    logic [mem_pkg::DATA_W-1:0] merged_word;
    logic [mem_pkg::DATA_W-1:0] load_word;
    logic [mem_pkg::DATA_W-1:0] display_word;
    logic                       wr_fire;

    // Right-justified byte with zero or sign fill
    function automatic logic [mem_pkg::DATA_W-1:0] ext_byte(
        input logic [BYTE_W-1:0] b,
        input logic              sgn
    );
        return {{(mem_pkg::DATA_W - BYTE_W){sgn & b[BYTE_W-1]}}, b};
    endfunction

    // Same for a half-word
    function automatic logic [mem_pkg::DATA_W-1:0] ext_half(
        input logic [HALF_W-1:0] h,
        input logic              sgn
    );
        return {{(mem_pkg::DATA_W - HALF_W){sgn & h[HALF_W-1]}}, h};
    endfunction

    assign wr_fire  = ram_en && ram_write;
    assign cur_word = mem[ram_addr];

    ////////////////////////////////////////////////////////////
    // Store merge and load extraction
    ////////////////////////////////////////////////////////////

    // Old bytes kept outside the enabled lanes
    always_comb
    begin
        for (int k = 0; k < mem_pkg::LANES; k++)
        begin
            merged_word[k*BYTE_W +: BYTE_W] = ram_sel[k] ? ram_wdata[k*BYTE_W +: BYTE_W]
                                                         : cur_word[k*BYTE_W +: BYTE_W];
        end
    end

    always_comb
    begin
        case (ram_sel)
            4'b0001: load_word = ext_byte(cur_word[BYTE_W-1:0], ram_signed);
            4'b0010: load_word = ext_byte(cur_word[BYTE_W +: BYTE_W], ram_signed);
            4'b0100: load_word = ext_byte(cur_word[2*BYTE_W +: BYTE_W], ram_signed);
            4'b1000: load_word = ext_byte(cur_word[3*BYTE_W +: BYTE_W], ram_signed);
            4'b0011: load_word = ext_half(cur_word[HALF_W-1:0], ram_signed);
            4'b1100: load_word = ext_half(cur_word[HALF_W +: HALF_W], ram_signed);
            4'b1111: load_word = cur_word;
            // Anything else reads as zero
            default: load_word = '0;
        endcase
    end

    // Forward a store to the viewer in the same edge
    assign display_word = (wr_fire && (ram_addr == display_addr)) ? merged_word
                                                                  : mem[display_addr];

    ////////////////////////////////////////////////////////////
    // Array and read registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // Clear every word
            for (int i = 0; i < DEPTH; i++)
            begin
                mem[i] <= '0;
            end
            ram_rdata    <= '0;
            display_data <= '0;
        end
        else
        begin
            if (wr_fire)
            begin
                mem[ram_addr] <= merged_word;
            end
            // Load result held until the next load
            if (ram_en && !ram_write)
            begin
                ram_rdata <= load_word;
            end
            display_data <= display_word;
        end
    end

endmodule

// ==== logic/apb_mem_port.sv ====
module apb_mem_port #(
    parameter int ADDR_BITS = 10
) (
    input  logic                        clk,
    input  logic                        rst,
    // APB slave side
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [ADDR_BITS-1:0]        paddr,
    input  logic [mem_pkg::DATA_W-1:0]  pwdata,
    input  mem_pkg::mem_op_e            pauser,
    output logic                        pready,
    output logic [mem_pkg::DATA_W-1:0]  prdata,
    output logic                        pslverr,
    // Lane aligner
    output logic [1:0]                  align_offset,
    output mem_pkg::mem_op_e            align_op,
    output logic [mem_pkg::DATA_W-1:0]  align_wdata,
    input  logic                        misaligned,
    input  logic [mem_pkg::LANES-1:0]   lane_sel,
    input  logic [mem_pkg::DATA_W-1:0]  lane_wdata,
    input  logic                        load_signed,
    // Memory side
    output logic                        ram_en,
    output logic                        ram_write,
    output logic [ADDR_BITS-3:0]        ram_addr,
    output logic [mem_pkg::LANES-1:0]   ram_sel,
    output logic [mem_pkg::DATA_W-1:0]  ram_wdata,
    output logic                        ram_signed,
    input  logic [mem_pkg::DATA_W-1:0]  ram_rdata
);

    mem_pkg::apb_state_e state;
    mem_pkg::apb_state_e state_next;

    // Response-cycle flags, captured in the access cycle
    logic err_q;
    logic write_q;

    ////////////////////////////////////////////////////////////
    // Phase FSM
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            // Setup cycle seen
            mem_pkg::APB_IDLE:   if (psel && !penable) state_next = mem_pkg::APB_ACCESS;
            // Fixed single wait state
            mem_pkg::APB_ACCESS: state_next = mem_pkg::APB_RESP;
            mem_pkg::APB_RESP:   state_next = mem_pkg::APB_IDLE;
            default:             state_next = mem_pkg::APB_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= mem_pkg::APB_IDLE;
            err_q   <= 1'b0;
            write_q <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (state == mem_pkg::APB_ACCESS)
            begin
                err_q   <= misaligned;
                write_q <= pwrite;
            end
        end
    end

    // Address offset, width and store data go to the aligner
    assign align_offset = paddr[1:0];
    assign align_op     = pauser;
    assign align_wdata  = pwdata;

    // One strobe per aligned transfer
    assign ram_en     = (state == mem_pkg::APB_ACCESS) && !misaligned;
    assign ram_write  = pwrite;
    assign ram_addr   = paddr[ADDR_BITS-1:2];
    assign ram_sel    = lane_sel;
    assign ram_wdata  = lane_wdata;
    assign ram_signed = load_signed;

    // Response
    assign pready  = (state == mem_pkg::APB_RESP);
    assign pslverr = pready && err_q;
    // Zero after a store or an error
    assign prdata  = (pready && !err_q && !write_q) ? ram_rdata : '0;

endmodule

// ==== logic/mem_subsys_top.sv ====
module mem_subsys_top #(
    parameter int ADDR_BITS = 10
) (
    input  logic                        clk,
    input  logic                        rst,
    // APB slave
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [ADDR_BITS-1:0]        paddr,
    input  logic [mem_pkg::DATA_W-1:0]  pwdata,
    input  mem_pkg::mem_op_e            pauser,
    output logic                        pready,
    output logic [mem_pkg::DATA_W-1:0]  prdata,
    output logic                        pslverr,
    // Debug viewer, word indexed
    input  logic [ADDR_BITS-3:0]        display_addr,
    output logic [mem_pkg::DATA_W-1:0]  display_data
);

    ////////////////////////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////////////////////////

    // Front end to aligner
    logic [1:0]                 align_offset;
    mem_pkg::mem_op_e           align_op;
    logic [mem_pkg::DATA_W-1:0] align_wdata;

    // Aligner results
    logic                       misaligned;
    logic [mem_pkg::LANES-1:0]  lane_sel;
    logic [mem_pkg::DATA_W-1:0] lane_wdata;
    logic                       load_signed;

    // Front end to memory
    logic                       ram_en;
    logic                       ram_write;
    logic [ADDR_BITS-3:0]       ram_addr;
    logic [mem_pkg::LANES-1:0]  ram_sel;
    logic [mem_pkg::DATA_W-1:0] ram_wdata;
    logic                       ram_signed;
    logic [mem_pkg::DATA_W-1:0] ram_rdata;

    apb_mem_port #(
        .ADDR_BITS (ADDR_BITS)
    ) u_apb_port (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .pauser       (pauser),
        .pready       (pready),
        .prdata       (prdata),
        .pslverr      (pslverr),
        .align_offset (align_offset),
        .align_op     (align_op),
        .align_wdata  (align_wdata),
        .misaligned   (misaligned),
        .lane_sel     (lane_sel),
        .lane_wdata   (lane_wdata),
        .load_signed  (load_signed),
        .ram_en       (ram_en),
        .ram_write    (ram_write),
        .ram_addr     (ram_addr),
        .ram_sel      (ram_sel),
        .ram_wdata    (ram_wdata),
        .ram_signed   (ram_signed),
        .ram_rdata    (ram_rdata)
    );

    access_align u_align (
        .align_offset (align_offset),
        .align_op     (align_op),
        .align_wdata  (align_wdata),
        .lane_sel     (lane_sel),
        .lane_wdata   (lane_wdata),
        .load_signed  (load_signed),
        .misaligned   (misaligned)
    );

    data_ram #(
        .ADDR_BITS (ADDR_BITS)
    ) u_ram (
        .clk          (clk),
        .rst          (rst),
        .ram_en       (ram_en),
        .ram_write    (ram_write),
        .ram_addr     (ram_addr),
        .ram_sel      (ram_sel),
        .ram_wdata    (ram_wdata),
        .ram_signed   (ram_signed),
        .display_addr (display_addr),
        .ram_rdata    (ram_rdata),
        .display_data (display_data)
    );

endmodule

// ==== dv/mem_apb_sva.sv ====
module mem_apb_sva (
    input  logic                clk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pready,
    input  logic                pslverr,
    input  logic                ram_en,
    input  logic                misaligned,
    input  mem_pkg::apb_state_e state
);

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////////////////////////
    // Response handshake
    ////////////////////////////////////////////////////////////

    // Ready only in the response phase after one wait state
    a_pready_in_resp: assert property (@(posedge clk) disable iff (rst)
        pready |-> (state == mem_pkg::APB_RESP) && $past(psel && penable)
                   && $past(psel && !penable, 2))
        else $error("pready not one wait state after a setup cycle");

    // Exactly one ready cycle per transfer
    a_pready_one_cycle: assert property (@(posedge clk) disable iff (rst)
        pready |=> !pready)
        else $error("pready held for more than one cycle");

    // Error response carries the aligner verdict from the access cycle
    a_err_from_align: assert property (@(posedge clk) disable iff (rst)
        pready |-> (pslverr == $past(misaligned)))
        else $error("pslverr does not match the misaligned flag of the access");

    // Host must be in the access phase while the slave works
    a_access_enabled: assert property (@(posedge clk) disable iff (rst)
        (state != mem_pkg::APB_IDLE) |-> (psel && penable))
        else $error("psel or penable dropped during a transfer");

    ////////////////////////////////////////////////////////////
    // Memory strobe
    ////////////////////////////////////////////////////////////

    // Good transfers strobe the memory, refused ones never do
    a_no_bad_strobe: assert property (@(posedge clk) disable iff (rst)
        pready |-> ($past(ram_en) != pslverr))
        else $error("ram_en on a misaligned access or missing on a good one");

    // Quiet outputs after reset
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> (state == mem_pkg::APB_IDLE && !pready && !pslverr && !ram_en))
        else $error("front end not idle after reset");

endmodule

// ==== dv/tb_mem_subsys.sv ====
module tb_mem_subsys;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_BITS = 10;
    localparam int PREADY_TIMEOUT = 20;

    typedef struct packed {
        logic                 wr;
        mem_pkg::mem_op_e     op;
        logic [ADDR_BITS-1:0] addr;
        logic [31:0]          wdata;
        logic [31:0]          exp_rdata;
        logic                 exp_err;
    } access_t;

    logic                 clk;
    logic                 rst;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [ADDR_BITS-1:0] paddr;
    logic [31:0]          pwdata;
    mem_pkg::mem_op_e     pauser;
    logic                 pready;
    logic [31:0]          prdata;
    logic                 pslverr;
    logic [ADDR_BITS-3:0] display_addr;
    logic [31:0]          display_data;

    // Byte-wide reference memory, little endian
    logic [7:0] model_bytes [1 << ADDR_BITS];
    access_t    access_q [$];
    int         seed = 70336;
    logic [31:0] rd;
    logic [31:0] rnd;
    logic        err;
    logic        wr;
    logic [ADDR_BITS-1:0] addr;
    mem_pkg::mem_op_e     op;

    mem_subsys_top #(.ADDR_BITS(ADDR_BITS)) DUT (.*);

    bind apb_mem_port mem_apb_sva u_apb_sva (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pready     (pready),
        .pslverr    (pslverr),
        .ram_en     (ram_en),
        .misaligned (misaligned),
        .state      (state)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic is_misaligned(input logic [ADDR_BITS-1:0] a,
                                           input mem_pkg::mem_op_e o);
        if (o == mem_pkg::MEM_WORD) return a[1:0] != 2'b00;
        if (o == mem_pkg::MEM_HALF || o == mem_pkg::MEM_HALF_U) return a[0];
        return 1'b0;
    endfunction

    function automatic logic [31:0] predict_load(input logic [ADDR_BITS-1:0] a,
                                                 input mem_pkg::mem_op_e o);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = model_bytes[a];
        b1 = model_bytes[a + 10'd1];
        case (o)
            mem_pkg::MEM_BYTE:   return {{24{b0[7]}}, b0};
            mem_pkg::MEM_BYTE_U: return {24'h0, b0};
            mem_pkg::MEM_HALF:   return {{16{b1[7]}}, b1, b0};
            mem_pkg::MEM_HALF_U: return {16'h0, b1, b0};
            default:             return {model_bytes[a + 10'd3], model_bytes[a + 10'd2], b1, b0};
        endcase
    endfunction

    // Refused accesses leave the model alone
    task automatic model_store(input logic [ADDR_BITS-1:0] a, input mem_pkg::mem_op_e o,
                               input logic [31:0] d);
        int n;
        n = (o == mem_pkg::MEM_WORD) ? 4
          : (o == mem_pkg::MEM_BYTE || o == mem_pkg::MEM_BYTE_U) ? 1 : 2;
        if (!is_misaligned(a, o))
        begin
            for (int k = 0; k < n; k++)
            begin
                model_bytes[a + ADDR_BITS'(k)] = d[8*k +: 8];
            end
        end
    endtask

    function automatic mem_pkg::mem_op_e pick_op(input int k);
        case (k)
            0:       return mem_pkg::MEM_BYTE;
            1:       return mem_pkg::MEM_BYTE_U;
            2:       return mem_pkg::MEM_HALF;
            3:       return mem_pkg::MEM_HALF_U;
            default: return mem_pkg::MEM_WORD;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Checking and APB driver
    ////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic apb_xfer(input logic w, input mem_pkg::mem_op_e o,
                            input logic [ADDR_BITS-1:0] a, input logic [31:0] d,
                            output logic [31:0] rdata, output logic e);
        int waited;
        // Setup phase
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= w;
        paddr   <= a;
        pwdata  <= d;
        pauser  <= o;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!pready && waited < PREADY_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        assert (pready)
        else
        begin
            $display("Timeout: pready never rose after the access phase began");
            abort_run();
        end
        // Always one wait state
        check_eq(waited, 32'd1, "wait states");
        rdata = prdata;
        e     = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Registered viewer, one cycle latency
    task automatic check_display(input logic [ADDR_BITS-3:0] idx, input logic [31:0] exp);
        @(posedge clk);
        display_addr <= idx;
        @(posedge clk);
        @(negedge clk);
        check_eq(display_data, exp, "display_data");
    endtask

    // Viewer sampled in the response cycle of a store
    task automatic check_display_at_ready(input logic [31:0] exp);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!pready && waited < PREADY_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        assert (pready)
        else
        begin
            $display("Timeout: pready never rose while watching the display port");
            abort_run();
        end
        check_eq(display_data, exp, "display after store");
    endtask

    task automatic add_access(input logic w, input mem_pkg::mem_op_e o,
                              input logic [ADDR_BITS-1:0] a, input logic [31:0] d,
                              input logic [31:0] exp, input logic e);
        access_t entry;
        entry = '{w, o, a, d, exp, e};
        access_q.push_back(entry);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed table
    ////////////////////////////////////////////////////////////

    task automatic build_table();
        // Cleared memory
        add_access(1'b0, mem_pkg::MEM_WORD,   10'h000, 32'h0,        32'h0,        1'b0);
        add_access(1'b0, mem_pkg::MEM_WORD,   10'h3FC, 32'h0,        32'h0,        1'b0);
        // Lanes of one word, signed and unsigned
        add_access(1'b1, mem_pkg::MEM_WORD,   10'h010, 32'h80FF7F01, 32'h0,        1'b0);
        add_access(1'b0, mem_pkg::MEM_BYTE,   10'h010, 32'h0,        32'h00000001, 1'b0);
        add_access(1'b0, mem_pkg::MEM_BYTE,   10'h011, 32'h0,        32'h0000007F, 1'b0);
        add_access(1'b0, mem_pkg::MEM_BYTE,   10'h012, 32'h0,        32'hFFFFFFFF, 1'b0);
        add_access(1'b0, mem_pkg::MEM_BYTE,   10'h013, 32'h0,        32'hFFFFFF80, 1'b0);
        add_access(1'b0, mem_pkg::MEM_BYTE_U, 10'h012, 32'h0,        32'h000000FF, 1'b0);
        add_access(1'b0, mem_pkg::MEM_BYTE_U, 10'h013, 32'h0,        32'h00000080, 1'b0);
        // Partial stores merge with old contents
        add_access(1'b1, mem_pkg::MEM_WORD,   10'h020, 32'h11223344, 32'h0,        1'b0);
        add_access(1'b1, mem_pkg::MEM_BYTE,   10'h021, 32'hAAAAAAC3, 32'h0,        1'b0);
        add_access(1'b1, mem_pkg::MEM_HALF_U, 10'h022, 32'hDEAD9876, 32'h0,        1'b0);
        add_access(1'b0, mem_pkg::MEM_WORD,   10'h020, 32'h0,        32'h9876C344, 1'b0);
        add_access(1'b0, mem_pkg::MEM_HALF,   10'h020, 32'h0,        32'hFFFFC344, 1'b0);
        add_access(1'b0, mem_pkg::MEM_HALF_U, 10'h020, 32'h0,        32'h0000C344, 1'b0);
        add_access(1'b0, mem_pkg::MEM_HALF,   10'h022, 32'h0,        32'hFFFF9876, 1'b0);
        add_access(1'b0, mem_pkg::MEM_HALF_U, 10'h022, 32'h0,        32'h00009876, 1'b0);
        // Misaligned accesses refused
        add_access(1'b1, mem_pkg::MEM_HALF,   10'h011, 32'h0000BEEF, 32'h0,        1'b1);
        add_access(1'b0, mem_pkg::MEM_HALF_U, 10'h013, 32'h0,        32'h0,        1'b1);
        add_access(1'b1, mem_pkg::MEM_WORD,   10'h012, 32'hDEADBEEF, 32'h0,        1'b1);
        add_access(1'b0, mem_pkg::MEM_WORD,   10'h011, 32'h0,        32'h0,        1'b1);
        add_access(1'b0, mem_pkg::MEM_WORD,   10'h010, 32'h0,        32'h80FF7F01, 1'b0);
    endtask

    initial
    begin
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        pauser       = mem_pkg::MEM_WORD;
        display_addr = '0;
        rst          = 1'b1;
        for (int i = 0; i < (1 << ADDR_BITS); i++)
        begin
            model_bytes[i] = 8'h00;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        check_display(8'h00, 32'h0);
        check_display(8'h3F, 32'h0);

        build_table();
        foreach (access_q[i])
        begin
            apb_xfer(access_q[i].wr, access_q[i].op, access_q[i].addr, access_q[i].wdata, rd, err);
            check_eq(rd, access_q[i].exp_rdata, $sformatf("table entry %0d prdata", i));
            check_eq({31'd0, err}, {31'd0, access_q[i].exp_err},
                     $sformatf("table entry %0d pslverr", i));
            if (access_q[i].wr)
            begin
                model_store(access_q[i].addr, access_q[i].op, access_q[i].wdata);
            end
        end

        // Viewer runs alongside an APB load
        fork
            apb_xfer(1'b0, mem_pkg::MEM_WORD, 10'h020, 32'h0, rd, err);
            check_display(8'h04, 32'h80FF7F01);
        join
        check_eq(rd, 32'h9876C344, "load during display read");
        // Store shows up on the viewer right after the write edge
        check_display(8'h09, 32'h0);
        fork
            apb_xfer(1'b1, mem_pkg::MEM_WORD, 10'h024, 32'h0BADF00D, rd, err);
            check_display_at_ready(32'h0BADF00D);
        join
        model_store(10'h024, mem_pkg::MEM_WORD, 32'h0BADF00D);

        ////////////////////////////////////////////////////////////
        // Random aligned pass in a small window
        ////////////////////////////////////////////////////////////
        for (int i = 0; i < 200; i++)
        begin
            rnd  = $random(seed);
            wr   = rnd[0];
            op   = pick_op(int'(rnd[15:8] % 8'd5));
            addr = 10'h100 + {4'd0, rnd[21:16]};
            if (op == mem_pkg::MEM_WORD)
                addr[1:0] = 2'b00;
            else if (op == mem_pkg::MEM_HALF || op == mem_pkg::MEM_HALF_U)
                addr[0] = 1'b0;
            rnd = $random(seed);
            apb_xfer(wr, op, addr, rnd, rd, err);
            check_eq(rd, wr ? 32'h0 : predict_load(addr, op), $sformatf("random %0d prdata", i));
            check_eq({31'd0, err}, 32'd0, $sformatf("random %0d pslverr", i));
            if (wr)
            begin
                model_store(addr, op, rnd);
            end
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== build.f ====
logic/mem_pkg.sv
logic/access_align.sv
logic/data_ram.sv
logic/apb_mem_port.sv
logic/mem_subsys_top.sv
dv/mem_apb_sva.sv
dv/tb_mem_subsys.sv

// ==== Makefile ====
TOP := tb_mem_subsys

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f build.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
